// File: hdl/acsPkg.sv
package acsPkg;

    localparam int sampleWidth    = 18;    // Signed sample and table components
    localparam int metricWidth    = 18;    // Unsigned, saturating
    localparam int laneCount      = 8;
    localparam int laneBits       = 3;
    localparam int stateCount     = 128;
    localparam int tableAddrWidth = 7;
    localparam int stepCount      = 16;    // Cycles per stage
    localparam int stepBits       = 4;
    localparam int inPairCount    = 4;
    localparam int symbolWidth    = 4;
    localparam int tbWordWidth    = 64;    // 16 symbols per word
    localparam int tbDepth        = 16;    // Two halves of 8 words
    localparam int tbAddrWidth    = 4;
    localparam int shortDelay     = 2;     // Positive tau
    localparam int longDelay      = 8;     // Negative tau

endpackage

// File: hdl/referenceTable.sv
module referenceTable import acsPkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          startFrame,
    input  logic                          setupValid,
    input  logic signed [sampleWidth-1:0] setupReal,
    input  logic signed [sampleWidth-1:0] setupImag,
    input  logic                          startStage,
    input  logic                          metricInValid,
    output logic signed [sampleWidth-1:0] entryReal [laneCount],
    output logic signed [sampleWidth-1:0] entryImag [laneCount]
);

    logic signed [sampleWidth-1:0] tableReal [stateCount];
    logic signed [sampleWidth-1:0] tableImag [stateCount];
    logic        [tableAddrWidth-1:0] writeAddr;
    logic        [stepBits-1:0]       stepIndex;

    always_ff @(posedge clk) begin
        if (reset || startFrame) begin
            writeAddr <= '0;
        end else if (setupValid) begin
            writeAddr <= writeAddr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (setupValid) begin
            tableReal[writeAddr] <= setupReal;
            tableImag[writeAddr] <= setupImag;
        end
    end

    // One step counter shared by all lanes
    always_ff @(posedge clk) begin
        if (reset || startStage) begin
            stepIndex <= '0;
        end else if (metricInValid) begin
            stepIndex <= stepIndex + 1'b1;
        end
    end

    // Lane L sees entry 8s+L
    always_comb begin
        for (int l = 0; l < laneCount; l++) begin
            entryReal[l] = tableReal[{stepIndex, laneBits'(l)}];
            entryImag[l] = tableImag[{stepIndex, laneBits'(l)}];
        end
    end

endmodule

// File: hdl/acsLane.sv
module acsLane import acsPkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic signed [sampleWidth-1:0] sampleReal,
    input  logic signed [sampleWidth-1:0] sampleImag,
    input  logic signed [sampleWidth-1:0] entryReal,
    input  logic signed [sampleWidth-1:0] entryImag,
    input  logic        [metricWidth-1:0] metricIn,
    input  logic                          metricInValid,
    output logic        [metricWidth-1:0] metricOut,
    output logic                          laneValid
);

    logic signed [sampleWidth:0]   diffReal, diffImag;
    logic        [sampleWidth:0]   absReal, absImag;
    logic        [metricWidth+2:0] total;

    // L1 distance as the branch metric
    assign diffReal = sampleReal - entryReal;
    assign diffImag = sampleImag - entryImag;
    assign absReal  = diffReal[sampleWidth] ? -diffReal : diffReal;
    assign absImag  = diffImag[sampleWidth] ? -diffImag : diffImag;
    assign total    = metricIn + absReal + absImag;

    always_ff @(posedge clk) begin
        metricOut <= (|total[metricWidth+2:metricWidth]) ? {metricWidth{1'b1}}  // Saturate
                                                         : total[metricWidth-1:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            laneValid <= 1'b0;
        end else begin
            laneValid <= metricInValid;
        end
    end

endmodule

// File: hdl/acsArray.sv
module acsArray import acsPkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          positiveTau,
    input  logic                          startBlock,
    input  logic signed [sampleWidth-1:0] sampleReal,
    input  logic signed [sampleWidth-1:0] sampleImag,
    input  logic signed [sampleWidth-1:0] entryReal [laneCount],
    input  logic signed [sampleWidth-1:0] entryImag [laneCount],
    input  logic        [metricWidth-1:0] metricIn [inPairCount],
    input  logic                          metricInValid,
    output logic        [metricWidth-1:0] laneMetric [laneCount],
    output logic                          laneValid
);

    logic signed [sampleWidth-1:0] heldReal, heldImag;
    logic        [metricWidth-1:0] laneIn [laneCount];
    logic        [laneCount-1:0]   validVec;

    // Sample held for the whole block
    always_ff @(posedge clk) begin
        if (startBlock) begin
            heldReal <= sampleReal;
            heldImag <= sampleImag;
        end
    end

    for (genvar g = 0; g < laneCount; g++) begin : gLane
        localparam logic [laneBits-1:0] idx = laneBits'(g);

        // Input 2*b2 + (positiveTau ? b0 : b1)
        assign laneIn[g] = metricIn[{idx[2], positiveTau ? idx[0] : idx[1]}];

        acsLane lane (
            .clk          (clk),
            .reset        (reset),
            .sampleReal   (heldReal),
            .sampleImag   (heldImag),
            .entryReal    (entryReal[g]),
            .entryImag    (entryImag[g]),
            .metricIn     (laneIn[g]),
            .metricInValid(metricInValid),
            .metricOut    (laneMetric[g]),
            .laneValid    (validVec[g])
        );
    end

    assign laneValid = validVec[0];    // All lanes run in lockstep

endmodule

// File: hdl/pathSelect.sv
module pathSelect import acsPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   positiveTau,
    input  logic [metricWidth-1:0] laneMetric [laneCount],
    input  logic                   laneValid,
    output logic [metricWidth-1:0] metricOut [laneCount],
    output logic                   metricOutValid,
    output logic [tbWordWidth-1:0] survivorWord,
    output logic                   survivorWrite,
    output logic                   startNextStage
);

    logic [metricWidth-1:0] delayLine [laneCount][longDelay];
    logic [metricWidth-1:0] path0 [laneCount];
    logic [metricWidth-1:0] selected [laneCount];
    logic [symbolWidth-1:0] survivorIndex [laneCount];
    logic [laneCount-1:0]   decision;
    logic [longDelay-1:0]   validSr;
    logic                   delayedValid;
    logic [stepBits-1:0]    windowCount;
    logic                   inWindow;
    logic                   compareCycle;

    // Metric history, tapped at 2 or 8 cycles
    always_ff @(posedge clk) begin
        for (int l = 0; l < laneCount; l++) begin
            delayLine[l][0] <= laneMetric[l];
            for (int t = 1; t < longDelay; t++) begin
                delayLine[l][t] <= delayLine[l][t-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            validSr <= '0;
        end else begin
            validSr <= {validSr[longDelay-2:0], laneValid};
        end
    end

    assign delayedValid = positiveTau ? validSr[shortDelay-1] : validSr[longDelay-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            windowCount <= '0;
        end else if (!delayedValid) begin
            windowCount <= '0;
        end else begin
            windowCount <= windowCount + 1'b1;
        end
    end

    // Half of the delayed steps are compared
    assign inWindow = positiveTau ? !windowCount[1]
                                  : (windowCount < stepBits'(stepCount / 2));
    assign compareCycle   = delayedValid && inWindow;
    assign survivorWrite  = compareCycle;
    assign startNextStage = compareCycle && (windowCount == '0);

    always_comb begin
        survivorWord = '0;
        for (int l = 0; l < laneCount; l++) begin
            path0[l]    = positiveTau ? delayLine[l][shortDelay-1] : delayLine[l][longDelay-1];
            decision[l] = laneMetric[l] < path0[l];    // Ties keep path0
            selected[l] = decision[l] ? laneMetric[l] : path0[l];
            if (positiveTau) begin
                survivorIndex[l] = {windowCount[3:2], decision[l], windowCount[0]};
                survivorWord[symbolWidth*(2*l) +: symbolWidth]   = survivorIndex[l];
                survivorWord[symbolWidth*(2*l+1) +: symbolWidth] = survivorIndex[l];
            end else begin
                survivorIndex[l] = {decision[l], windowCount[2:0]};
                survivorWord[symbolWidth*l +: symbolWidth]       = survivorIndex[l];
                survivorWord[symbolWidth*(l+8) +: symbolWidth]   = survivorIndex[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < laneCount; l++) begin
            metricOut[l] <= selected[l];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            metricOutValid <= 1'b0;
        end else begin
            metricOutValid <= compareCycle;
        end
    end

endmodule

// File: hdl/tracebackMemory.sv
module tracebackMemory import acsPkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flipPingPong,
    input  logic [tbWordWidth-1:0]    survivorWord,
    input  logic                      survivorWrite,
    input  logic [tableAddrWidth-1:0] winner,
    output logic [symbolWidth-1:0]    detectedBits
);

    logic                   pingPong;
    logic [tbAddrWidth-2:0] writeCount;
    logic [tbWordWidth-1:0] tbMem [tbDepth];
    logic [tbWordWidth-1:0] readWord;

    // Write half, reads use the other one
    always_ff @(posedge clk) begin
        if (reset) begin
            pingPong <= 1'b0;
        end else if (flipPingPong) begin
            pingPong <= ~pingPong;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            writeCount <= '0;
        end else if (survivorWrite) begin
            writeCount <= writeCount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (survivorWrite) begin
            tbMem[{pingPong, writeCount}] <= survivorWord;
        end
    end

    assign readWord = tbMem[{~pingPong, winner[tableAddrWidth-1:symbolWidth]}];

    always_ff @(posedge clk) begin
        detectedBits <= readWord[symbolWidth*winner[symbolWidth-1:0] +: symbolWidth];
    end

endmodule

// File: hdl/acsStage4.sv
module acsStage4 import acsPkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          positiveTau,
    input  logic                          startFrame,
    input  logic                          startBlock,
    input  logic                          startStage,
    input  logic signed [sampleWidth-1:0] sampleReal,
    input  logic signed [sampleWidth-1:0] sampleImag,
    input  logic                          setupValid,
    input  logic signed [sampleWidth-1:0] setupReal,
    input  logic signed [sampleWidth-1:0] setupImag,
    input  logic                          metricInValid,
    input  logic        [metricWidth-1:0] metricIn [inPairCount],
    input  logic                          flipPingPong,
    input  logic     [tableAddrWidth-1:0] winner,
    output logic                          metricOutValid,
    output logic        [metricWidth-1:0] metricOut [laneCount],
    output logic                          startNextStage,
    output logic        [symbolWidth-1:0] detectedBits
);

    logic signed [sampleWidth-1:0] entryReal [laneCount];
    logic signed [sampleWidth-1:0] entryImag [laneCount];
    logic        [metricWidth-1:0] laneMetric [laneCount];
    logic                          laneValid;
    logic        [tbWordWidth-1:0] survivorWord;
    logic                          survivorWrite;

    referenceTable refTable (
        .clk          (clk),
        .reset        (reset),
        .startFrame   (startFrame),
        .setupValid   (setupValid),
        .setupReal    (setupReal),
        .setupImag    (setupImag),
        .startStage   (startStage),
        .metricInValid(metricInValid),
        .entryReal    (entryReal),
        .entryImag    (entryImag)
    );

    acsArray lanes (
        .clk          (clk),
        .reset        (reset),
        .positiveTau  (positiveTau),
        .startBlock   (startBlock),
        .sampleReal   (sampleReal),
        .sampleImag   (sampleImag),
        .entryReal    (entryReal),
        .entryImag    (entryImag),
        .metricIn     (metricIn),
        .metricInValid(metricInValid),
        .laneMetric   (laneMetric),
        .laneValid    (laneValid)
    );

    pathSelect select (
        .clk           (clk),
        .reset         (reset),
        .positiveTau   (positiveTau),
        .laneMetric    (laneMetric),
        .laneValid     (laneValid),
        .metricOut     (metricOut),
        .metricOutValid(metricOutValid),
        .survivorWord  (survivorWord),
        .survivorWrite (survivorWrite),
        .startNextStage(startNextStage)
    );

    tracebackMemory traceback (
        .clk          (clk),
        .reset        (reset),
        .flipPingPong (flipPingPong),
        .survivorWord (survivorWord),
        .survivorWrite(survivorWrite),
        .winner       (winner),
        .detectedBits (detectedBits)
    );

endmodule

// File: verification/acsStage4_asserts.sv
module acsStage4_asserts
    import acsPkg::*;
(
    input logic                   clk,
    input logic                   reset,
    input logic                   positiveTau,
    input logic                   laneValid,
    input logic                   survivorWrite,
    input logic                   startNextStage,
    input logic                   metricOutValid,
    input logic [metricWidth-1:0] metricOut [laneCount]
);

    // A stage opens after a cycle without a compare
    stageOpensAfterGap: assert property (@(posedge clk) disable iff (reset)
        startNextStage |-> !$past(survivorWrite))
        else $error("startNextStage right after a compare cycle");

    writeAfterShortDelay: assert property (@(posedge clk) disable iff (reset)
        (survivorWrite && positiveTau) |-> $past(laneValid, shortDelay))
        else $error("positive tau compare without a lane step two cycles earlier");

    writeAfterLongDelay: assert property (@(posedge clk) disable iff (reset)
        (survivorWrite && !positiveTau) |-> $past(laneValid, longDelay))
        else $error("negative tau compare without a lane step eight cycles earlier");

    for (genvar g = 0; g < laneCount; g++) begin : gKnown
        metricKnown: assert property (@(posedge clk) disable iff (reset)
            metricOutValid |-> !$isunknown(metricOut[g]))
            else $error("metricOut lane %0d has unknown bits", g);
    end

endmodule

bind pathSelect acsStage4_asserts checks (
    .clk           (clk),
    .reset         (reset),
    .positiveTau   (positiveTau),
    .laneValid     (laneValid),
    .survivorWrite (survivorWrite),
    .startNextStage(startNextStage),
    .metricOutValid(metricOutValid),
    .metricOut     (metricOut)
);

// File: verification/acsStage4Tb.sv
module acsStage4Tb
    import acsPkg::*;
();

    localparam int maxMetric = 2**metricWidth - 1;

    logic clk = 1'b0;
    logic reset, positiveTau, startFrame, startBlock, startStage;
    logic setupValid, metricInValid, flipPingPong;
    logic signed [sampleWidth-1:0] sampleReal, sampleImag, setupReal, setupImag;
    logic [metricWidth-1:0] metricIn [inPairCount];
    logic [tableAddrWidth-1:0] winner;
    logic metricOutValid, startNextStage;
    logic [metricWidth-1:0] metricOut [laneCount];
    logic [symbolWidth-1:0] detectedBits;

    logic [31:0] rngState = 32'd87070;
    int tabR [stateCount];
    int tabI [stateCount];
    int inM [stepCount][inPairCount];
    int laneOut [stepCount][laneCount];            // Model lane outputs per step
    logic [tbWordWidth-1:0] modelWord [laneCount]; // Eight words per stage

    acsStage4 dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic int smallSigned();
        logic [31:0] r;
        r = nextRandom();
        return int'($signed(r[12:0]));    // Within +-2^12
    endfunction

    function automatic int absInt(int v);
        return (v < 0) ? -v : v;
    endfunction

    task automatic stopOnError();
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkMetric(input string name, input logic [metricWidth-1:0] got,
                               input logic [metricWidth-1:0] expected);
        if (got !== expected) begin
            $display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, expected);
            stopOnError();
        end
    endtask

    task automatic checkBits(input string name, input logic [symbolWidth-1:0] got,
                             input logic [symbolWidth-1:0] expected);
        if (got !== expected) begin
            $display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, expected);
            stopOnError();
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("mismatch at time %0t: %s is %b, expected %b", $time, name, got, expected);
            stopOnError();
        end
    endtask

    task automatic checkIdle();
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            checkFlag("metricOutValid", metricOutValid, 1'b0);
            checkFlag("startNextStage", startNextStage, 1'b0);
        end
        @(posedge clk);
    endtask

    task automatic loadTable();
        @(posedge clk);
        startFrame <= 1'b1;
        @(posedge clk);
        startFrame <= 1'b0;
        for (int e = 0; e < stateCount; e++) begin
            tabR[e] = smallSigned();
            tabI[e] = smallSigned();
            setupValid <= 1'b1;
            setupReal  <= sampleWidth'(tabR[e]);
            setupImag  <= sampleWidth'(tabI[e]);
            @(posedge clk);
        end
        setupValid <= 1'b0;
    endtask

    task automatic runStage(input logic pos, input logic saturate);
        int d, k, count, src, v, p0, p1, sampR, sampI;
        logic dec, expValid;
        logic [3:0] kk;
        logic [symbolWidth-1:0] idx;
        d = pos ? shortDelay : longDelay;
        count = 0;
        loadTable();
        sampR = saturate ? 2**(sampleWidth-1) - 1 : smallSigned();    // Far sample saturates
        sampI = saturate ? 2**(sampleWidth-1) - 1 : smallSigned();
        for (int s = 0; s < stepCount; s++) begin
            for (int i = 0; i < inPairCount; i++) begin
                v = int'(nextRandom() & 32'hffff);
                inM[s][i] = saturate ? maxMetric - (v & 255) : v;
            end
            for (int l = 0; l < laneCount; l++) begin
                src = 2 * (l / 4) + (pos ? l % 2 : (l / 2) % 2);
                v = inM[s][src] + absInt(sampR - tabR[8*s+l]) + absInt(sampI - tabI[8*s+l]);
                laneOut[s][l] = (v > maxMetric) ? maxMetric : v;
            end
        end
        positiveTau <= pos;
        startBlock  <= 1'b1;
        startStage  <= 1'b1;
        sampleReal  <= sampleWidth'(sampR);
        sampleImag  <= sampleWidth'(sampI);
        @(posedge clk);
        startBlock <= 1'b0;
        startStage <= 1'b0;
        for (int c = 0; c < 30; c++) begin
            metricInValid <= (c < stepCount);
            for (int i = 0; i < inPairCount; i++) begin
                metricIn[i] <= metricWidth'(inM[c % stepCount][i]);
            end
            @(negedge clk);
            k = c - 2 - d;    // Window step of the output seen now
            expValid = (k >= 0) && (k < stepCount) && (pos ? (k % 4 < 2) : (k < 8));
            checkFlag("startNextStage", startNextStage, c == d + 1);
            checkFlag("metricOutValid", metricOutValid, expValid);
            if (expValid) begin
                kk = 4'(k);
                for (int l = 0; l < laneCount; l++) begin
                    p1 = laneOut[k+d][l];
                    p0 = laneOut[k][l];
                    dec = p1 < p0;    // Ties keep path0
                    checkMetric($sformatf("metricOut[%0d]", l), metricOut[l],
                                metricWidth'(dec ? p1 : p0));
                    idx = pos ? {kk[3:2], dec, kk[0]} : {dec, kk[2:0]};
                    if (pos) begin
                        modelWord[count][2*symbolWidth*l +: 2*symbolWidth] = {idx, idx};
                    end else begin
                        modelWord[count][symbolWidth*l +: symbolWidth]     = idx;
                        modelWord[count][symbolWidth*(l+8) +: symbolWidth] = idx;
                    end
                end
            end
            if (metricOutValid === 1'b1) begin
                count++;
            end
            @(posedge clk);
        end
        metricInValid <= 1'b0;
        if (count != stepCount / 2) begin
            $display("expected %0d metric outputs in the stage, saw %0d", stepCount / 2, count);
            stopOnError();
        end
    endtask

    // Flip halves, then read every winner of the last stage
    task automatic readBack();
        logic [tbWordWidth-1:0] word;
        flipPingPong <= 1'b1;
        @(posedge clk);
        flipPingPong <= 1'b0;
        for (int a = 0; a < stateCount; a++) begin
            winner <= tableAddrWidth'(a);
            @(posedge clk);
            @(negedge clk);
            word = modelWord[a / 16];
            checkBits($sformatf("detectedBits[%0d]", a), detectedBits,
                      word[symbolWidth*(a % 16) +: symbolWidth]);
            @(posedge clk);
        end
    endtask

    initial begin
        reset         <= 1'b1;
        positiveTau   <= 1'b1;
        startFrame    <= 1'b0;
        startBlock    <= 1'b0;
        startStage    <= 1'b0;
        setupValid    <= 1'b0;
        metricInValid <= 1'b0;
        flipPingPong  <= 1'b0;
        sampleReal    <= '0;
        sampleImag    <= '0;
        setupReal     <= '0;
        setupImag     <= '0;
        winner        <= '0;
        for (int i = 0; i < inPairCount; i++) begin
            metricIn[i] <= '0;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        checkIdle();
        runStage(1'b1, 1'b0);    // Positive tau
        readBack();
        runStage(1'b0, 1'b0);    // Negative tau
        readBack();
        runStage(1'b1, 1'b1);    // Saturated, all ties
        readBack();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: all.f
hdl/acsPkg.sv
hdl/referenceTable.sv
hdl/acsLane.sv
hdl/acsArray.sv
hdl/pathSelect.sv
hdl/tracebackMemory.sv
hdl/acsStage4.sv
verification/acsStage4_asserts.sv
verification/acsStage4Tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the failure line in the log
verilator --binary --timing --assert -Wno-fatal --top-module acsStage4Tb \
    -f all.f -o acsSim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/acsSim > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log
grep -q "=== PASS ===" sim.log || exit 1
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
